// ==== all.f ====
+incdir+include
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_hazard.sv
hw/rv_core_top.sv
verification/tb_checker.sv
verification/tb_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - include_dirs:
      - include
    files:
      - hw/rv_pkg.sv
      - hw/rv_fetch.sv
      - hw/rv_decode.sv
      - hw/rv_regfile.sv
      - hw/rv_alu.sv
      - hw/rv_hazard.sv
      - hw/rv_core_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_checker.sv
      - verification/tb_core.sv

// ==== verification/tb_core.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_core;

	localparam int ROWS = 6;

	logic sys_clk;
	logic sys_rst;
	logic inst_cyc;
	logic inst_stb;
	logic [31:0] inst_addr;
	logic inst_ack;
	logic [31:0] inst_data;
	logic inst_stall;
	logic data_stb;
	logic data_we;
	logic [3:0] data_be;
	logic data_ack;
	logic [31:0] data_addr;
	logic [31:0] data_data_w;
	logic [31:0] data_data_r;
	logic [31:0] exp_addr;
	logic [31:0] exp_data;
	int store_count;
	int errors;
	integer seed;
	int epoch; // bumped on every reset so stale bus replies are dropped
	logic [31:0] prog [0:ROWS-1][0:7];
	logic [31:0] row_addr [0:ROWS-1];
	logic [31:0] row_data [0:ROWS-1];
	logic [31:0] imem [0:15];

	rv_core_top dut (
		.inst_cyc(inst_cyc), .inst_stb(inst_stb), .inst_addr(inst_addr),
		.inst_ack(inst_ack), .inst_data(inst_data), .inst_stall(inst_stall),
		.data_stb(data_stb), .data_we(data_we), .data_be(data_be), .data_ack(data_ack),
		.data_addr(data_addr), .data_data_w(data_data_w), .data_data_r(data_data_r),
		.sys_clk(sys_clk), .sys_rst(sys_rst)
	);

	tb_checker chk (
		.sys_clk(sys_clk), .data_stb(data_stb), .data_we(data_we), .data_be(data_be),
		.data_ack(data_ack), .data_addr(data_addr), .data_data_w(data_data_w),
		.exp_addr(exp_addr), .exp_data(exp_data), .store_count(store_count),
		.errors(errors)
	);

	// instruction encoders in rv32i field layout
	function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
	endfunction

	function automatic logic [31:0] itype(input logic [31:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm[11:0], rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] stype(input logic [31:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE};
	endfunction

	function automatic logic [31:0] btype(input logic [31:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
	endfunction

	function automatic logic [31:0] jal_word(input logic [31:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
	endfunction

	function automatic logic [31:0] fetch_word(input logic [31:0] addr);
		return (addr < 32'd64) ? imem[addr[5:2]] : `RV_NOP; // past the program is nops
	endfunction

	task build_table();
		for (int r = 0; r < ROWS; r++)
			for (int k = 0; k < 8; k++)
				prog[r][k] = `RV_NOP;
		// alu chain through forwarding starting from 12 and -5
		prog[0][0] = itype(12, 0, 3'b000, 1, `RV_OP_IMM);
		prog[0][1] = itype(-5, 0, 3'b000, 2, `RV_OP_IMM);
		prog[0][2] = rtype(7'h00, 2, 1, 3'b000, 3); // x3 = 7
		prog[0][3] = rtype(7'h20, 2, 3, 3'b000, 4); // x4 = 12
		prog[0][4] = rtype(7'h00, 3, 4, 3'b100, 5); // x5 = 11
		prog[0][5] = rtype(7'h00, 1, 2, 3'b010, 6); // slt gives 1
		prog[0][6] = rtype(7'h00, 6, 5, 3'b110, 7); // 11 | 1
		prog[0][7] = stype(32'h100, 7, 0);
		row_addr[0] = 32'h100;
		row_data[0] = 32'd11;
		// lui and shifts
		prog[1][0] = {20'h12345, 5'd1, `RV_OP_LUI};
		prog[1][1] = itype(32'h678, 1, 3'b000, 1, `RV_OP_IMM);
		prog[1][2] = itype(4, 1, 3'b001, 2, `RV_OP_IMM); // 0x23456780
		prog[1][3] = itype(8, 2, 3'b101, 3, `RV_OP_IMM); // 0x00234567
		prog[1][4] = {20'h80000, 5'd4, `RV_OP_LUI};
		prog[1][5] = itype(32'h404, 4, 3'b101, 5, `RV_OP_IMM); // srai by 4
		prog[1][6] = rtype(7'h00, 5, 3, 3'b000, 6);
		prog[1][7] = stype(32'h104, 6, 0);
		row_addr[1] = 32'h104;
		row_data[1] = 32'hf823_4567;
		// load then immediate use
		prog[2][0] = itype(5, 0, 3'b000, 3, `RV_OP_IMM);
		prog[2][1] = itype(32'h40, 0, 3'b010, 1, `RV_OP_LOAD);
		prog[2][2] = rtype(7'h00, 3, 1, 3'b000, 2);
		prog[2][3] = stype(32'h108, 2, 0);
		row_addr[2] = 32'h108;
		row_data[2] = 32'hdead_0045; // memory pattern at 0x40 plus 5
		// beq not taken and bne taken over two marked addi
		prog[3][0] = itype(16, 0, 3'b000, 5, `RV_OP_IMM);
		prog[3][1] = btype(8, 0, 5, 3'b000);
		prog[3][2] = itype(1, 5, 3'b000, 5, `RV_OP_IMM);
		prog[3][3] = btype(12, 0, 5, 3'b001);
		prog[3][4] = itype(256, 5, 3'b000, 5, `RV_OP_IMM);
		prog[3][5] = itype(512, 5, 3'b000, 5, `RV_OP_IMM);
		prog[3][6] = stype(32'h10c, 5, 0);
		row_addr[3] = 32'h10c;
		row_data[3] = 32'd17;
		// beq taken and bne not taken
		prog[4][0] = itype(3, 0, 3'b000, 6, `RV_OP_IMM);
		prog[4][1] = btype(12, 6, 6, 3'b000);
		prog[4][2] = itype(64, 6, 3'b000, 6, `RV_OP_IMM);
		prog[4][3] = itype(128, 6, 3'b000, 6, `RV_OP_IMM);
		prog[4][4] = btype(8, 6, 6, 3'b001);
		prog[4][5] = itype(4, 6, 3'b000, 6, `RV_OP_IMM);
		prog[4][6] = stype(32'h110, 6, 0);
		row_addr[4] = 32'h110;
		row_data[4] = 32'd7;
		// jal links pc+4 and skips two
		prog[5][0] = jal_word(12, 1);
		prog[5][1] = itype(99, 0, 3'b000, 1, `RV_OP_IMM);
		prog[5][2] = itype(98, 0, 3'b000, 1, `RV_OP_IMM);
		prog[5][3] = stype(32'h114, 1, 0);
		row_addr[5] = 32'h114;
		row_data[5] = 32'd4;
	endtask

	task reset_dut();
		sys_rst = 1'b1;
		epoch = epoch + 1;
		for (int c = 0; c < 3; c++) begin
			@(posedge sys_clk);
			#1;
		end
		sys_rst = 1'b0;
	endtask

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	// instruction slave with random stall and ack delay
	initial begin : inst_bus
		int n;
		int d;
		int ep;
		forever begin
			@(posedge sys_clk);
			#1;
			inst_ack = 1'b0;
			if (inst_cyc && inst_stb && !sys_rst) begin
				ep = epoch;
				n = $unsigned($random(seed)) % 3;
				inst_stall = (n != 0);
				while (n > 0) begin
					@(posedge sys_clk);
					#1;
					n = n - 1;
				end
				inst_stall = 1'b0;
				d = $unsigned($random(seed)) % 3;
				while (d > 0) begin
					@(posedge sys_clk);
					#1;
					d = d - 1;
				end
				if (ep == epoch && inst_cyc) begin
					inst_data = fetch_word(inst_addr);
					inst_ack = 1'b1;
				end
			end
		end
	end

	// data slave whose reads return addr xor a fixed tag
	initial begin : data_bus
		int d;
		int ep;
		forever begin
			@(posedge sys_clk);
			#1;
			data_ack = 1'b0;
			if (data_stb && !sys_rst) begin
				ep = epoch;
				d = $unsigned($random(seed)) % 4;
				while (d > 0) begin
					@(posedge sys_clk);
					#1;
					d = d - 1;
				end
				if (ep == epoch && data_stb) begin
					data_data_r = data_addr ^ 32'hdead_0000;
					data_ack = 1'b1;
				end
			end
		end
	end

	initial begin
		int cycles;
		seed = 32'h3f85;
		epoch = 0;
		sys_rst = 1'b1;
		inst_ack = 1'b0;
		inst_stall = 1'b0;
		inst_data = `RV_NOP;
		data_ack = 1'b0;
		data_data_r = '0;
		exp_addr = '0;
		exp_data = '0;
		build_table();
		for (int i = 0; i < ROWS; i++) begin
			sys_rst = 1'b1;
			for (int k = 0; k < 16; k++)
				imem[k] = (k < 8) ? prog[i][k] : `RV_NOP;
			exp_addr = row_addr[i];
			exp_data = row_data[i];
			chk.start_row();
			reset_dut();
			cycles = 0;
			while (store_count == 0 && cycles < 2000) begin
				@(posedge sys_clk);
				#1;
				cycles = cycles + 1;
			end
			if (store_count == 0)
				chk.report_timeout(i);
			cycles = 0;
			while (cycles < 40) begin // drain to catch a second store
				@(posedge sys_clk);
				#1;
				cycles = cycles + 1;
			end
			chk.end_row(i);
		end
		chk.summary();
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== verification/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
	input logic sys_clk,
	input logic data_stb,
	input logic data_we,
	input logic [3:0] data_be,
	input logic data_ack,
	input logic [31:0] data_addr,
	input logic [31:0] data_data_w,
	input logic [31:0] exp_addr,
	input logic [31:0] exp_data,
	output int store_count,
	output int errors
);

	int row_errors;
	int tests;

	initial begin
		store_count = 0;
		errors = 0;
		row_errors = 0;
		tests = 0;
	end

	always @(posedge sys_clk) begin
		// word accesses only
		if (data_stb && data_ack && (data_be !== 4'hf)) begin
			$display("Error data_be expected %h got %h", 4'hf, data_be);
			row_errors = row_errors + 1;
		end
		if (data_stb && data_we && data_ack) begin
			store_count = store_count + 1;
			if (store_count == 1) begin // only the first store of a row is compared
				if (data_addr !== exp_addr) begin
					$display("Error data_addr expected %h got %h", exp_addr, data_addr);
					row_errors = row_errors + 1;
				end
				if (data_data_w !== exp_data) begin
					$display("Error data_data_w expected %h got %h", exp_data, data_data_w);
					row_errors = row_errors + 1;
				end
			end
		end
	end

	task start_row();
		store_count = 0;
		row_errors = 0;
	endtask

	task report_timeout(input int row);
		$display("test %0d: no store was seen before the time limit ran out", row);
		row_errors = row_errors + 1;
	endtask

	task end_row(input int row);
		tests = tests + 1;
		if (store_count > 1) begin
			$display("test %0d: expected one store but saw %0d", row, store_count);
			row_errors = row_errors + 1;
		end
		if (row_errors == 0)
			$display("test %0d: ok", row);
		else
			$display("test %0d: failed with %0d errors", row, row_errors);
		errors = errors + row_errors;
	endtask

	task summary();
		$display("%0d tests run, %0d errors", tests, errors);
	endtask

endmodule

// ==== hw/rv_core_top.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_top (
	// instruction port
	output logic inst_cyc,
	output logic inst_stb,
	output rv_pkg::addr_t inst_addr,
	input logic inst_ack,
	input rv_pkg::instr_t inst_data,
	input logic inst_stall,
	// data port
	output logic data_stb,
	output logic data_we,
	output logic [3:0] data_be,
	input logic data_ack,
	output rv_pkg::addr_t data_addr,
	output rv_pkg::word_t data_data_w,
	input rv_pkg::word_t data_data_r,
	input logic sys_clk,
	input logic sys_rst
);

	rv_pkg::if_id_t if_id;
	rv_pkg::id_ex_t id_ex;
	rv_pkg::ex_mem_t ex_mem;
	rv_pkg::mem_wb_t mem_wb;
	rv_pkg::instr_t dec_instr;
	rv_pkg::ctrl_t dec_ctrl;
	rv_pkg::word_t dec_imm;
	rv_pkg::reg_idx_t dec_rs1;
	rv_pkg::reg_idx_t dec_rs2;
	rv_pkg::reg_idx_t dec_rd;
	rv_pkg::word_t rf_a;
	rv_pkg::word_t rf_b;
	rv_pkg::fwd_sel_e fwd_a;
	rv_pkg::fwd_sel_e fwd_b;
	rv_pkg::word_t opnd_a; // forwarded rs1
	rv_pkg::word_t opnd_b; // forwarded rs2, also store data
	rv_pkg::word_t alu_a;
	rv_pkg::word_t alu_b;
	rv_pkg::word_t alu_result;
	logic alu_equal;
	rv_pkg::addr_t target_pc;
	rv_pkg::addr_t link_pc;
	logic taken;
	logic redirect;
	logic data_busy;
	logic stall;
	logic flush;
	logic freeze;

	function automatic rv_pkg::word_t fwd_value(
		input rv_pkg::fwd_sel_e sel,
		input rv_pkg::word_t rf,
		input rv_pkg::word_t mem,
		input rv_pkg::word_t wb
	);
		case (sel)
			rv_pkg::fwd_mem: return mem;
			rv_pkg::fwd_wb: return wb;
			default: return rf;
		endcase
	endfunction

	rv_fetch u_fetch (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.stall(stall || freeze),
		.flush(flush),
		.redirect(redirect),
		.redirect_pc(target_pc),
		.inst_cyc(inst_cyc),
		.inst_stb(inst_stb),
		.inst_addr(inst_addr),
		.inst_ack(inst_ack),
		.inst_stall(inst_stall),
		.inst_data(inst_data),
		.if_id(if_id)
	);

	assign dec_instr = if_id.valid ? if_id.instr : `RV_NOP; // empty slot decodes as nop

	rv_decode u_decode (
		.instr(dec_instr),
		.ctrl(dec_ctrl),
		.imm(dec_imm),
		.rs1(dec_rs1),
		.rs2(dec_rs2),
		.rd(dec_rd)
	);

	rv_regfile u_regfile (
		.sys_clk(sys_clk),
		.we(mem_wb.reg_write),
		.waddr(mem_wb.rd),
		.wdata(mem_wb.wdata),
		.raddr_a(dec_rs1),
		.raddr_b(dec_rs2),
		.rdata_a(rf_a),
		.rdata_b(rf_b)
	);

	rv_hazard u_hazard (
		.id_ex(id_ex),
		.ex_mem(ex_mem),
		.mem_wb(mem_wb),
		.dec_rs1(dec_rs1),
		.dec_rs2(dec_rs2),
		.redirect(redirect),
		.data_busy(data_busy),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.stall(stall),
		.flush(flush),
		.freeze(freeze)
	);

	// execute
	assign opnd_a = fwd_value(fwd_a, id_ex.rs1_val, ex_mem.result, mem_wb.wdata);
	assign opnd_b = fwd_value(fwd_b, id_ex.rs2_val, ex_mem.result, mem_wb.wdata);
	assign link_pc = id_ex.pc + 32'd4;
	assign target_pc = id_ex.pc + id_ex.imm; // branch and jal share the adder
	assign alu_a = id_ex.ctrl.lui ? '0 : opnd_a;
	assign alu_b = id_ex.ctrl.is_jal ? link_pc : (id_ex.ctrl.use_imm ? id_ex.imm : opnd_b);

	rv_alu u_alu (
		.op(id_ex.ctrl.alu_op),
		.a(alu_a),
		.b(alu_b),
		.result(alu_result),
		.equal(alu_equal)
	);

	assign taken = id_ex.ctrl.is_jal
		|| (id_ex.ctrl.is_branch && (alu_equal != id_ex.ctrl.branch_ne));
	assign redirect = taken && !data_busy; // wait until the pipe moves

	// data bus master straight from the memory stage
	assign data_stb = ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write;
	assign data_we = ex_mem.ctrl.mem_write;
	assign data_be = 4'b1111; // word accesses only
	assign data_addr = ex_mem.result;
	assign data_data_w = ex_mem.store_data;
	assign data_busy = data_stb && !data_ack;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			id_ex.ctrl <= '0;
			ex_mem.ctrl <= '0;
			mem_wb.reg_write <= 1'b0;
		end else if (!freeze) begin
			if (flush || stall) begin
				id_ex.ctrl <= '0; // bubble
			end else begin
				id_ex <= '{ctrl: dec_ctrl, pc: if_id.pc, rs1_val: rf_a, rs2_val: rf_b,
					rs1: dec_rs1, rs2: dec_rs2, rd: dec_rd, imm: dec_imm};
			end
			ex_mem <= '{ctrl: id_ex.ctrl, result: alu_result, store_data: opnd_b, rd: id_ex.rd};
			mem_wb <= '{reg_write: ex_mem.ctrl.reg_write, rd: ex_mem.rd,
				wdata: ex_mem.ctrl.mem_read ? data_data_r : ex_mem.result};
		end
	end

endmodule

// ==== hw/rv_hazard.sv ====
`timescale 1ns/1ps

module rv_hazard (
	input rv_pkg::id_ex_t id_ex,
	input rv_pkg::ex_mem_t ex_mem,
	input rv_pkg::mem_wb_t mem_wb,
	input rv_pkg::reg_idx_t dec_rs1,
	input rv_pkg::reg_idx_t dec_rs2,
	input logic redirect,
	input logic data_busy,
	output rv_pkg::fwd_sel_e fwd_a,
	output rv_pkg::fwd_sel_e fwd_b,
	output logic stall,
	output logic flush,
	output logic freeze
);

	logic mem_ok;
	logic wb_ok;

	// youngest writer wins
	function automatic rv_pkg::fwd_sel_e pick(
		input rv_pkg::reg_idx_t src,
		input logic mem_hit_ok,
		input rv_pkg::reg_idx_t mem_rd,
		input logic wb_hit_ok,
		input rv_pkg::reg_idx_t wb_rd
	);
		if (mem_hit_ok && (mem_rd == src))
			return rv_pkg::fwd_mem;
		else if (wb_hit_ok && (wb_rd == src))
			return rv_pkg::fwd_wb;
		else
			return rv_pkg::fwd_rf;
	endfunction

	// a load in memory has only its address, so it cannot forward
	assign mem_ok = ex_mem.ctrl.reg_write && !ex_mem.ctrl.mem_read && (ex_mem.rd != '0);
	assign wb_ok = mem_wb.reg_write && (mem_wb.rd != '0);

	always_comb begin
		fwd_a = pick(id_ex.rs1, mem_ok, ex_mem.rd, wb_ok, mem_wb.rd);
		fwd_b = pick(id_ex.rs2, mem_ok, ex_mem.rd, wb_ok, mem_wb.rd);
	end

	// load in execute feeding the instruction in decode
	assign stall = id_ex.ctrl.mem_read && (id_ex.rd != '0)
		&& ((id_ex.rd == dec_rs1) || (id_ex.rd == dec_rs2));

	assign flush = redirect;
	assign freeze = data_busy; // whole pipe waits on the data bus

endmodule

// ==== hw/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu (
	input rv_pkg::alu_op_e op,
	input rv_pkg::word_t a,
	input rv_pkg::word_t b,
	output rv_pkg::word_t result,
	output logic equal
);

	logic [4:0] shamt;

	assign shamt = b[4:0];
	assign equal = (a == b); // beq / bne compare

	always_comb begin
		case (op)
			rv_pkg::alu_add: result = a + b;
			rv_pkg::alu_sub: result = a - b;
			rv_pkg::alu_and: result = a & b;
			rv_pkg::alu_or: result = a | b;
			rv_pkg::alu_xor: result = a ^ b;
			rv_pkg::alu_slt: result = {31'b0, $signed(a) < $signed(b)};
			rv_pkg::alu_sltu: result = {31'b0, a < b};
			rv_pkg::alu_sll: result = a << shamt;
			rv_pkg::alu_srl: result = a >> shamt;
			rv_pkg::alu_sra: result = $signed(a) >>> shamt;
			rv_pkg::alu_pass_b: result = b;
			default: result = '0;
		endcase
	end

endmodule

// ==== hw/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
	input logic sys_clk,
	input logic we,
	input rv_pkg::reg_idx_t waddr,
	input rv_pkg::word_t wdata,
	input rv_pkg::reg_idx_t raddr_a,
	input rv_pkg::reg_idx_t raddr_b,
	output rv_pkg::word_t rdata_a,
	output rv_pkg::word_t rdata_b
);

	rv_pkg::word_t regs [0:31];

	// x0 is hardwired, same-cycle write is passed through
	function automatic rv_pkg::word_t read_port(input rv_pkg::reg_idx_t addr);
		if (addr == '0)
			return '0;
		else if (we && (waddr == addr))
			return wdata;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge sys_clk) begin
		if (we && (waddr != '0))
			regs[waddr] <= wdata;
	end

	always_comb begin
		rdata_a = read_port(raddr_a);
		rdata_b = read_port(raddr_b);
	end

endmodule

// ==== hw/rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_decode (
	input rv_pkg::instr_t instr,
	output rv_pkg::ctrl_t ctrl,
	output rv_pkg::word_t imm,
	output rv_pkg::reg_idx_t rs1,
	output rv_pkg::reg_idx_t rs2,
	output rv_pkg::reg_idx_t rd
);

	rv_pkg::word_t imm_i;
	rv_pkg::word_t imm_s;
	rv_pkg::word_t imm_b;
	rv_pkg::word_t imm_u;
	rv_pkg::word_t imm_j;

	// funct3 to alu op, shared by reg and imm forms
	function automatic rv_pkg::alu_op_e alu_sel(
		input logic [2:0] funct3,
		input logic alt,
		input logic reg_form
	);
		case (funct3)
			3'b000: return (reg_form && alt) ? rv_pkg::alu_sub : rv_pkg::alu_add;
			3'b001: return rv_pkg::alu_sll;
			3'b010: return rv_pkg::alu_slt;
			3'b011: return rv_pkg::alu_sltu;
			3'b100: return rv_pkg::alu_xor;
			3'b101: return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
			3'b110: return rv_pkg::alu_or;
			default: return rv_pkg::alu_and;
		endcase
	endfunction

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		ctrl = '0; // unknown opcode ends up as a nop
		ctrl.alu_op = rv_pkg::alu_add;
		imm = '0;
		rs1 = '0;
		rs2 = '0;
		rd = '0;
		case (instr[6:0])
			`RV_OP_REG: begin
				ctrl.alu_op = alu_sel(instr[14:12], instr[30], 1'b1);
				ctrl.reg_write = 1'b1;
				rs1 = instr[19:15];
				rs2 = instr[24:20];
				rd = instr[11:7];
			end
			`RV_OP_IMM: begin
				ctrl.alu_op = alu_sel(instr[14:12], instr[30], 1'b0);
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				imm = imm_i; // shamt sits in the low five bits
				rs1 = instr[19:15];
				rd = instr[11:7];
			end
			`RV_OP_LOAD: begin
				ctrl.use_imm = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.reg_write = 1'b1;
				imm = imm_i;
				rs1 = instr[19:15];
				rd = instr[11:7];
			end
			`RV_OP_STORE: begin
				ctrl.use_imm = 1'b1;
				ctrl.mem_write = 1'b1;
				imm = imm_s;
				rs1 = instr[19:15];
				rs2 = instr[24:20];
			end
			`RV_OP_BRANCH: begin
				ctrl.is_branch = 1'b1;
				ctrl.branch_ne = instr[12]; // funct3 001 is bne
				imm = imm_b;
				rs1 = instr[19:15];
				rs2 = instr[24:20];
			end
			`RV_OP_LUI: begin
				ctrl.use_imm = 1'b1;
				ctrl.lui = 1'b1;
				ctrl.reg_write = 1'b1;
				imm = imm_u;
				rd = instr[11:7];
			end
			`RV_OP_JAL: begin
				ctrl.alu_op = rv_pkg::alu_pass_b; // link value on operand b
				ctrl.is_jal = 1'b1;
				ctrl.reg_write = 1'b1;
				imm = imm_j;
				rd = instr[11:7];
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== hw/rv_fetch.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_fetch (
	input logic sys_clk,
	input logic sys_rst,
	input logic stall,
	input logic flush,
	input logic redirect,
	input rv_pkg::addr_t redirect_pc,
	output logic inst_cyc,
	output logic inst_stb,
	output rv_pkg::addr_t inst_addr,
	input logic inst_ack,
	input logic inst_stall,
	input rv_pkg::instr_t inst_data,
	output rv_pkg::if_id_t if_id
);

	rv_pkg::fetch_state_e state;
	rv_pkg::fetch_state_e after_ack;
	rv_pkg::addr_t pc; // address of the outstanding or next request
	rv_pkg::addr_t redir_pc;
	logic discard; // outstanding response belongs to the old path
	rv_pkg::if_id_t pend; // skid entry while decode holds if_id
	logic ack_now;
	logic keep;
	logic slot_free;

	assign ack_now = inst_ack && (state != rv_pkg::fetch_idle);
	assign keep = ack_now && !discard && !redirect;
	assign slot_free = !stall || !if_id.valid;
	// response parked in pend blocks the next request
	assign after_ack = (keep && !slot_free) ? rv_pkg::fetch_idle : rv_pkg::fetch_request;

	assign inst_cyc = (state != rv_pkg::fetch_idle);
	assign inst_stb = inst_cyc; // held until ack
	assign inst_addr = pc;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= rv_pkg::fetch_idle;
		end else begin
			case (state)
				rv_pkg::fetch_idle: begin
					if (!pend.valid)
						state <= rv_pkg::fetch_request;
				end
				rv_pkg::fetch_request: begin
					if (inst_ack)
						state <= after_ack;
					else if (!inst_stall)
						state <= rv_pkg::fetch_wait_ack; // taken by the slave
				end
				default: begin
					if (inst_ack)
						state <= after_ack;
				end
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pc <= `RV_RESET_PC;
			discard <= 1'b0;
		end else if (ack_now) begin
			if (redirect)
				pc <= redirect_pc;
			else if (discard)
				pc <= redir_pc;
			else
				pc <= pc + 32'd4;
			discard <= 1'b0;
		end else if (redirect) begin
			if (state == rv_pkg::fetch_idle) begin
				pc <= redirect_pc;
			end else begin
				// address must stay put until the ack
				redir_pc <= redirect_pc;
				discard <= 1'b1;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst || flush) begin
			if_id.valid <= 1'b0;
			pend.valid <= 1'b0;
		end else if (slot_free) begin
			if (pend.valid) begin
				if_id <= pend;
				pend.valid <= 1'b0;
			end else if (keep) begin
				if_id <= '{instr: inst_data, pc: pc, valid: 1'b1};
			end else begin
				if_id.valid <= 1'b0; // consumed, nothing new
			end
		end else if (keep) begin
			pend <= '{instr: inst_data, pc: pc, valid: 1'b1};
		end
	end

endmodule

// ==== hw/rv_pkg.sv ====
`include "rv_consts.svh"

package rv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t; // byte address
	typedef logic [4:0] reg_idx_t;
	typedef logic [31:0] instr_t;

	typedef enum logic [3:0] {
		alu_add = `RV_ALU_ADD,
		alu_sub = `RV_ALU_SUB,
		alu_and = `RV_ALU_AND,
		alu_or = `RV_ALU_OR,
		alu_xor = `RV_ALU_XOR,
		alu_slt = `RV_ALU_SLT,
		alu_sltu = `RV_ALU_SLTU,
		alu_sll = `RV_ALU_SLL,
		alu_srl = `RV_ALU_SRL,
		alu_sra = `RV_ALU_SRA,
		alu_pass_b = `RV_ALU_PASS_B
	} alu_op_e;

	// where an execute operand comes from
	typedef enum logic [1:0] {
		fwd_rf,
		fwd_mem,
		fwd_wb
	} fwd_sel_e;

	typedef enum logic [1:0] {
		fetch_idle,
		fetch_request,
		fetch_wait_ack
	} fetch_state_e;

	typedef struct packed {
		instr_t instr;
		addr_t pc;
		logic valid;
	} if_id_t;

	typedef struct packed {
		alu_op_e alu_op;
		logic use_imm; // operand b is the immediate
		logic mem_read;
		logic mem_write;
		logic reg_write;
		logic is_branch;
		logic branch_ne; // bne instead of beq
		logic is_jal;
		logic lui; // operand a forced to zero
	} ctrl_t;

	typedef struct packed {
		ctrl_t ctrl;
		addr_t pc;
		word_t rs1_val;
		word_t rs2_val;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
		word_t imm;
	} id_ex_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t result;
		word_t store_data;
		reg_idx_t rd;
	} ex_mem_t;

	typedef struct packed {
		logic reg_write;
		reg_idx_t rd;
		word_t wdata;
	} mem_wb_t;

endpackage

// ==== include/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// major opcodes of the supported subset
`define RV_OP_LUI 7'b0110111
`define RV_OP_JAL 7'b1101111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD 7'b0000011
`define RV_OP_STORE 7'b0100011
`define RV_OP_IMM 7'b0010011
`define RV_OP_REG 7'b0110011

`define RV_NOP 32'h0000_0013 // addi x0,x0,0

// alu operation codes
`define RV_ALU_ADD 4'd0
`define RV_ALU_SUB 4'd1
`define RV_ALU_AND 4'd2
`define RV_ALU_OR 4'd3
`define RV_ALU_XOR 4'd4
`define RV_ALU_SLT 4'd5
`define RV_ALU_SLTU 4'd6
`define RV_ALU_SLL 4'd7
`define RV_ALU_SRL 4'd8
`define RV_ALU_SRA 4'd9
`define RV_ALU_PASS_B 4'd10

`endif
